//--- ip_decoder_pkg.sv
package ip_decoder_pkg;

	////////////////////////////////////////
	// Basic widths
	////////////////////////////////////////
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] ipv4_addr_t;
	typedef logic [15:0] udp_port_t;
	typedef logic [7:0]  ip_proto_t;
	typedef logic [4:0]  hdr_idx_t;

	localparam int IPV4_HDR_BYTES = 20;
	localparam int UDP_HDR_BYTES  = 8;

	localparam ip_proto_t PROTO_UDP = 8'd17;

	////////////////////////////////////////
	// Header layouts, first wire byte at the MSB
	////////////////////////////////////////
	typedef struct packed {
		logic [3:0]  version;
		logic [3:0]  hdr_len;      // In 32-bit words
		logic [7:0]  service;
		logic [15:0] total_len;
		logic [15:0] ident;
		logic [2:0]  flags;
		logic [12:0] frag_offset;  // In 8-byte units
		logic [7:0]  ttl;
		ip_proto_t   protocol;
		logic [15:0] checksum;
		ipv4_addr_t  src_addr;
		ipv4_addr_t  dst_addr;
	} ipv4_header_t;

	typedef struct packed {
		udp_port_t   src_port;
		udp_port_t   dst_port;
		logic [15:0] length;
		logic [15:0] checksum;
	} udp_header_t;

	// Packet classification reported with ip_done
	typedef enum logic [1:0] {
		msg_unsupported = 2'b00,
		msg_udp         = 2'b10
	} msg_type_t;

endpackage

//--- ip_header_capture.sv
`timescale 1ns/1ps

module ip_header_capture (
	input  logic                         CLK,
	input  logic                         RST,
	input  logic                         hdr_wr,
	input  ip_decoder_pkg::hdr_idx_t     hdr_idx,
	input  ip_decoder_pkg::byte_t        in_data,
	output ip_decoder_pkg::ipv4_header_t hdr
);
	import ip_decoder_pkg::*;

	// One header byte per write, steered to its field
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			hdr <= '0;
		end else if (hdr_wr) begin
			case (hdr_idx)
				5'd0: begin
					hdr.version <= in_data[7:4];
					hdr.hdr_len <= in_data[3:0];
				end
				5'd1:  hdr.service          <= in_data;
				5'd2:  hdr.total_len[15:8]  <= in_data;
				5'd3:  hdr.total_len[7:0]   <= in_data;
				5'd4:  hdr.ident[15:8]      <= in_data;
				5'd5:  hdr.ident[7:0]       <= in_data;
				// Flags share a byte with the top of the offset
				5'd6: begin
					hdr.flags              <= in_data[7:5];
					hdr.frag_offset[12:8]  <= in_data[4:0];
				end
				5'd7:  hdr.frag_offset[7:0] <= in_data;
				5'd8:  hdr.ttl              <= in_data;
				5'd9:  hdr.protocol         <= in_data;
				5'd10: hdr.checksum[15:8]   <= in_data;
				5'd11: hdr.checksum[7:0]    <= in_data;
				5'd12: hdr.src_addr[31:24]  <= in_data;
				5'd13: hdr.src_addr[23:16]  <= in_data;
				5'd14: hdr.src_addr[15:8]   <= in_data;
				5'd15: hdr.src_addr[7:0]    <= in_data;
				5'd16: hdr.dst_addr[31:24]  <= in_data;
				5'd17: hdr.dst_addr[23:16]  <= in_data;
				5'd18: hdr.dst_addr[15:8]   <= in_data;
				5'd19: hdr.dst_addr[7:0]    <= in_data;
				default: ;
			endcase
		end
	end

endmodule

//--- udp_rx.sv
`timescale 1ns/1ps

module udp_rx #(
	parameter ip_decoder_pkg::udp_port_t LOCAL_UDP_PORT = 16'h0001
) (
	input  logic                        CLK,
	input  logic                        RST,

	input  logic                        udp_en,
	input  ip_decoder_pkg::byte_t       in_data,
	input  logic                        in_data_vld,

	output ip_decoder_pkg::udp_header_t udp_header,
	output ip_decoder_pkg::byte_t       udp_data,
	output logic                        udp_data_vld,
	output logic                        udp_done
);
	import ip_decoder_pkg::*;

	localparam int CNT_W   = $clog2(UDP_HDR_BYTES + 1);
	localparam int SHIFT_W = 8 * (UDP_HDR_BYTES - 1);

	logic [CNT_W-1:0]   byte_cnt;
	logic [SHIFT_W-1:0] hdr_shift;
	udp_header_t        hdr_next;
	logic               hdr_byte;
	logic               hdr_last;
	logic               port_ok;
	logic               fwd;

	////////////////////////////////////////
	// UDP header collection
	////////////////////////////////////////
	assign hdr_byte = udp_en && in_data_vld && (byte_cnt != CNT_W'(UDP_HDR_BYTES));
	assign hdr_last = hdr_byte && (byte_cnt == CNT_W'(UDP_HDR_BYTES - 1));
	assign hdr_next = {hdr_shift, in_data};

	// Payload only after a full header with our port
	assign fwd = udp_en && in_data_vld && (byte_cnt == CNT_W'(UDP_HDR_BYTES)) && port_ok;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			byte_cnt     <= '0;
			port_ok      <= 1'b0;
			udp_header   <= '0;
			udp_data_vld <= 1'b0;
			udp_done     <= 1'b0;
		end else begin
			if (!udp_en)
				byte_cnt <= '0;
			else if (hdr_byte)
				byte_cnt <= byte_cnt + 1'b1;

			if (hdr_last) begin
				udp_header <= hdr_next;
				port_ok    <= (hdr_next.dst_port == LOCAL_UDP_PORT);
			end else if (!udp_en) begin
				port_ok    <= 1'b0;
			end

			udp_data_vld <= fwd;

			// End of stream, single pulse
			udp_done <= udp_en && !in_data_vld && !udp_done;
		end
	end

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (hdr_byte)
			hdr_shift <= {hdr_shift[SHIFT_W-9:0], in_data};
		if (fwd)
			udp_data <= in_data;
	end

endmodule

//--- ip_rx_ctrl.sv
`timescale 1ns/1ps

module ip_rx_ctrl #(
	parameter ip_decoder_pkg::ipv4_addr_t LOCAL_IP_ADDR  = 32'hC0A8_0001,
	parameter int                         UDP_WAIT_LIMIT = 2000
) (
	input  logic                         CLK,
	input  logic                         RST,

	input  logic                         ip_en,
	input  logic                         in_data_vld,
	input  ip_decoder_pkg::ipv4_header_t hdr,
	input  logic                         udp_done,

	output logic                         hdr_wr,
	output ip_decoder_pkg::hdr_idx_t     hdr_idx,
	output logic                         udp_en,
	output ip_decoder_pkg::ipv4_header_t ip_header,
	output ip_decoder_pkg::msg_type_t    ip_type,
	output logic                         ip_done
);
	import ip_decoder_pkg::*;

	localparam int WAIT_W = $clog2(UDP_WAIT_LIMIT + 1);

	typedef enum logic [2:0] {
		st_idle,
		st_header,
		st_check,
		st_udp,
		st_drain,
		st_done
	} state_t;

	state_t            state;
	state_t            next_state;
	hdr_idx_t          byte_cnt;
	logic [WAIT_W-1:0] wait_cnt;
	logic              accept;
	logic              last_hdr_byte;
	logic              wait_expired;

	////////////////////////////////////////
	// Header byte strobes
	////////////////////////////////////////
	// First byte is taken straight from idle so no header byte is lost
	assign hdr_wr  = in_data_vld && ((state == st_idle && ip_en) || state == st_header);
	assign hdr_idx = (state == st_header) ? byte_cnt : '0;

	assign last_hdr_byte = (byte_cnt == hdr_idx_t'(IPV4_HDR_BYTES - 1));

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			byte_cnt <= '0;
		end else if (hdr_wr) begin
			byte_cnt <= hdr_idx + 1'b1;
		end else if (state == st_idle) begin
			byte_cnt <= '0;
		end
	end

	////////////////////////////////////////
	// Address and protocol check
	////////////////////////////////////////
	assign accept = (hdr.dst_addr == LOCAL_IP_ADDR) && (hdr.protocol == PROTO_UDP);

	// UDP stage starts in the check cycle, the first UDP byte is already on the bus
	assign udp_en  = (state == st_check && accept) || state == st_udp;
	assign ip_done = (state == st_done);

	// Watchdog on the UDP stage
	assign wait_expired = (wait_cnt == WAIT_W'(UDP_WAIT_LIMIT - 1));

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wait_cnt <= '0;
		end else if (state == st_udp) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else begin
			wait_cnt <= '0;
		end
	end

	////////////////////////////////////////
	// Packet FSM
	////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (ip_en && in_data_vld)
					next_state = st_header;
			end
			st_header: begin
				if (!in_data_vld)
					next_state = st_done;        // Truncated header
				else if (last_hdr_byte)
					next_state = st_check;
			end
			st_check: begin
				if (accept)
					next_state = st_udp;
				else if (in_data_vld)
					next_state = st_drain;
				else
					next_state = st_done;
			end
			st_udp: begin
				if (udp_done || wait_expired)
					next_state = st_done;
			end
			st_drain: begin
				if (!in_data_vld)
					next_state = st_done;
			end
			st_done:  next_state = st_idle;
			default:  next_state = st_idle;
		endcase
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state     <= st_idle;
			ip_header <= '0;
			ip_type   <= msg_unsupported;
		end else begin
			state <= next_state;
			if (state == st_check) begin
				if (accept) begin
					ip_header <= hdr;
					ip_type   <= msg_udp;
				end else begin
					ip_type   <= msg_unsupported;
				end
			end else if (state == st_udp && !udp_done && wait_expired) begin
				ip_type <= msg_unsupported;
			end else if (state == st_header && !in_data_vld) begin
				ip_type <= msg_unsupported;
			end
		end
	end

endmodule

//--- ip_decoder_top.sv
`timescale 1ns/1ps

module ip_decoder_top #(
	parameter ip_decoder_pkg::ipv4_addr_t LOCAL_IP_ADDR  = 32'hC0A8_0001,
	parameter ip_decoder_pkg::udp_port_t  LOCAL_UDP_PORT = 16'h0001,
	parameter int                         UDP_WAIT_LIMIT = 2000
) (
	input  logic                         CLK,
	input  logic                         RST,

	input  ip_decoder_pkg::byte_t        in_data,
	input  logic                         in_data_vld,
	input  logic                         ip_en,

	output ip_decoder_pkg::ipv4_header_t ip_header,
	output ip_decoder_pkg::msg_type_t    ip_type,
	output logic                         ip_done,

	output ip_decoder_pkg::udp_header_t  udp_header,
	output ip_decoder_pkg::byte_t        udp_data,
	output logic                         udp_data_vld
);
	import ip_decoder_pkg::*;

	logic         hdr_wr;
	hdr_idx_t     hdr_idx;
	ipv4_header_t hdr;
	logic         udp_en;
	logic         udp_done;

	ip_rx_ctrl #(
		.LOCAL_IP_ADDR  (LOCAL_IP_ADDR),
		.UDP_WAIT_LIMIT (UDP_WAIT_LIMIT)
	) i_ip_rx_ctrl (
		.CLK         (CLK),
		.RST         (RST),
		.ip_en       (ip_en),
		.in_data_vld (in_data_vld),
		.hdr         (hdr),
		.udp_done    (udp_done),
		.hdr_wr      (hdr_wr),
		.hdr_idx     (hdr_idx),
		.udp_en      (udp_en),
		.ip_header   (ip_header),
		.ip_type     (ip_type),
		.ip_done     (ip_done)
	);

	ip_header_capture i_ip_header_capture (
		.CLK     (CLK),
		.RST     (RST),
		.hdr_wr  (hdr_wr),
		.hdr_idx (hdr_idx),
		.in_data (in_data),
		.hdr     (hdr)
	);

	udp_rx #(
		.LOCAL_UDP_PORT (LOCAL_UDP_PORT)
	) i_udp_rx (
		.CLK          (CLK),
		.RST          (RST),
		.udp_en       (udp_en),
		.in_data      (in_data),
		.in_data_vld  (in_data_vld),
		.udp_header   (udp_header),
		.udp_data     (udp_data),
		.udp_data_vld (udp_data_vld),
		.udp_done     (udp_done)
	);

endmodule

//--- ip_decoder_props.sv
`timescale 1ns/1ps

module ip_decoder_props (
	input logic CLK,
	input logic RST,
	input logic ip_done,
	input logic udp_data_vld,
	input logic in_data_vld
);

	// One done pulse per packet
	a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
		ip_done |=> !ip_done)
		else $error("ip_done stayed high for two cycles");

	a_no_data_in_reset: assert property (@(posedge CLK)
		RST |-> !udp_data_vld)
		else $error("udp_data_vld high during reset");

	// Payload byte is the stream byte of the cycle before
	a_data_follows_input: assert property (@(posedge CLK) disable iff (RST)
		udp_data_vld |-> $past(in_data_vld))
		else $error("udp_data_vld without a valid input byte one cycle earlier");

endmodule

bind ip_decoder_top ip_decoder_props i_ip_decoder_props (
	.CLK          (CLK),
	.RST          (RST),
	.ip_done      (ip_done),
	.udp_data_vld (udp_data_vld),
	.in_data_vld  (in_data_vld)
);

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS  = 10,
	parameter int RST_CYCLES = 2
) (
	output logic CLK,
	output logic RST
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// Reset held over the first rising edges
	initial begin
		RST = 1'b1;
		repeat (RST_CYCLES) @(posedge CLK);
		RST <= 1'b0;
	end

endmodule

//--- tb_ip_decoder.sv
`timescale 1ns/1ps

module tb_ip_decoder;
	import ip_decoder_pkg::*;

	localparam ipv4_addr_t LOCAL_IP      = 32'hC0A8_0001;
	localparam udp_port_t  LOCAL_PORT    = 16'h0001;
	localparam int         WAIT_LIMIT    = 64;
	localparam int         DONE_TIMEOUT  = 200;
	localparam int         RESET_TIMEOUT = 20;

	logic         CLK;
	logic         RST;
	byte_t        in_data;
	logic         in_data_vld;
	logic         ip_en;
	ipv4_header_t ip_header;
	msg_type_t    ip_type;
	logic         ip_done;
	udp_header_t  udp_header;
	byte_t        udp_data;
	logic         udp_data_vld;

	int           errors;
	int           checks;
	int           done_cnt;
	int           done_seen;
	msg_type_t    last_type;
	byte_t        rx_q[$];
	byte_t        exp_q[$];
	logic [31:0]  lcg_state;
	ipv4_header_t last_accepted;

	tb_clock_gen i_tb_clock_gen (
		.CLK (CLK),
		.RST (RST)
	);

	ip_decoder_top #(
		.LOCAL_IP_ADDR  (LOCAL_IP),
		.LOCAL_UDP_PORT (LOCAL_PORT),
		.UDP_WAIT_LIMIT (WAIT_LIMIT)
	) i_ip_decoder_top (
		.CLK          (CLK),
		.RST          (RST),
		.in_data      (in_data),
		.in_data_vld  (in_data_vld),
		.ip_en        (ip_en),
		.ip_header    (ip_header),
		.ip_type      (ip_type),
		.ip_done      (ip_done),
		.udp_header   (udp_header),
		.udp_data     (udp_data),
		.udp_data_vld (udp_data_vld)
	);

	// Output monitor sampled mid-cycle
	always @(negedge CLK) begin
		if (!RST) begin
			if (ip_done) begin
				done_cnt  = done_cnt + 1;
				last_type = ip_type;
			end
			if (udp_data_vld)
				rx_q.push_back(udp_data);
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic ipv4_header_t make_ip_header(input ipv4_addr_t dst,
			input ip_proto_t proto, input logic [15:0] ident, input int n_pay);
		ipv4_header_t h;
		h.version     = 4'd4;
		h.hdr_len     = 4'd5;
		h.service     = 8'h2E;
		h.total_len   = 16'(IPV4_HDR_BYTES + UDP_HDR_BYTES + n_pay);
		h.ident       = ident;
		h.flags       = 3'b101;
		h.frag_offset = 13'h0ABC;   // Odd value to exercise the split byte
		h.ttl         = 8'd64;
		h.protocol    = proto;
		h.checksum    = 16'hB861 ^ ident;
		h.src_addr    = 32'hC0A8_000A;
		h.dst_addr    = dst;
		return h;
	endfunction

	function automatic udp_header_t make_udp_header(input udp_port_t dst, input int n_pay);
		udp_header_t u;
		u.src_port = 16'hD431;
		u.dst_port = dst;
		u.length   = 16'(UDP_HDR_BYTES + n_pay);
		u.checksum = 16'h5A3C;
		return u;
	endfunction

	task automatic check_value(input string name, input logic [159:0] got,
			input logic [159:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic check_payload();
		int n;
		check_value("udp_data count", rx_q.size(), exp_q.size());
		n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
		for (int i = 0; i < n; i++)
			check_value("udp_data", rx_q[i], exp_q[i]);
	endtask

	task automatic send_packet(input byte_t pkt[$]);
		for (int i = 0; i < pkt.size(); i++) begin
			@(posedge CLK);
			in_data     <= pkt[i];
			in_data_vld <= 1'b1;
			ip_en       <= (i == 0);
		end
		@(posedge CLK);
		in_data     <= '0;
		in_data_vld <= 1'b0;
		ip_en       <= 1'b0;
	endtask

	task automatic wait_for_done(input int start);
		int cycles;
		cycles = 0;
		while (done_cnt == start && cycles < DONE_TIMEOUT) begin
			@(posedge CLK);
			cycles++;
		end
		if (done_cnt == start) begin
			errors++;
			$display("Timeout: no ip_done pulse within %0d cycles", DONE_TIMEOUT);
		end
	endtask

	// Wire order is IPv4 header then UDP header then payload
	task automatic run_packet(input ipv4_header_t ih, input udp_header_t uh, input int n_pay);
		byte_t pkt[$];
		int    start;
		exp_q = {};
		rx_q  = {};
		for (int i = 0; i < IPV4_HDR_BYTES; i++)
			pkt.push_back(ih[$bits(ipv4_header_t) - 1 - 8 * i -: 8]);
		for (int i = 0; i < UDP_HDR_BYTES; i++)
			pkt.push_back(uh[$bits(udp_header_t) - 1 - 8 * i -: 8]);
		for (int i = 0; i < n_pay; i++) begin
			lcg_state = lcg_next(lcg_state);
			pkt.push_back(lcg_state[23:16]);
			exp_q.push_back(lcg_state[23:16]);
		end
		start = done_cnt;
		send_packet(pkt);
		wait_for_done(start);
		// Short gap so a second done pulse would be counted
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		done_seen = done_cnt - start;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic accepted_udp_packet(input logic [15:0] ident, input int n_pay);
		ipv4_header_t ih;
		udp_header_t  uh;
		ih = make_ip_header(LOCAL_IP, PROTO_UDP, ident, n_pay);
		uh = make_udp_header(LOCAL_PORT, n_pay);
		run_packet(ih, uh, n_pay);
		check_value("ip_done pulses", done_seen, 1);
		check_value("ip_type", last_type, msg_udp);
		check_value("ip_header", ip_header, ih);
		check_value("udp_header", udp_header, uh);
		check_payload();
		last_accepted = ih;
	endtask

	task automatic rejected_packet(input ipv4_addr_t dst, input ip_proto_t proto,
			input logic [15:0] ident);
		ipv4_header_t ih;
		udp_header_t  uh;
		ih = make_ip_header(dst, proto, ident, 10);
		uh = make_udp_header(LOCAL_PORT, 10);
		run_packet(ih, uh, 10);
		check_value("ip_done pulses", done_seen, 1);
		check_value("ip_type", last_type, msg_unsupported);
		check_value("ip_header", ip_header, last_accepted);
		check_value("udp_data_vld strobes", rx_q.size(), 0);
	endtask

	task automatic wrong_udp_port(input logic [15:0] ident);
		ipv4_header_t ih;
		udp_header_t  uh;
		ih = make_ip_header(LOCAL_IP, PROTO_UDP, ident, 9);
		uh = make_udp_header(16'h0050, 9);
		run_packet(ih, uh, 9);
		check_value("ip_done pulses", done_seen, 1);
		check_value("ip_type", last_type, msg_udp);
		check_value("ip_header", ip_header, ih);
		check_value("udp_header", udp_header, uh);
		check_value("udp_data_vld strobes", rx_q.size(), 0);
		last_accepted = ih;
	endtask

	task automatic udp_watchdog_abort(input logic [15:0] ident);
		ipv4_header_t ih;
		udp_header_t  uh;
		ih = make_ip_header(LOCAL_IP, PROTO_UDP, ident, 100);
		uh = make_udp_header(LOCAL_PORT, 100);
		run_packet(ih, uh, 100);
		check_value("ip_done pulses", done_seen, 1);
		check_value("ip_type", last_type, msg_unsupported);
		check_value("ip_header", ip_header, ih);
		last_accepted = ih;
	endtask

	initial begin
		int cycles;
		in_data       = '0;
		in_data_vld   = 1'b0;
		ip_en         = 1'b0;
		errors        = 0;
		checks        = 0;
		done_cnt      = 0;
		done_seen     = 0;
		last_type     = msg_unsupported;
		lcg_state     = 32'd25;
		last_accepted = '0;
		cycles        = 0;

		while (RST !== 1'b0 && cycles < RESET_TIMEOUT) begin
			@(posedge CLK);
			cycles++;
		end
		if (RST !== 1'b0) begin
			errors++;
			$display("Timeout: reset was never released");
		end
		@(negedge CLK);
		check_value("ip_header after reset", ip_header, '0);
		check_value("udp_header after reset", udp_header, '0);
		check_value("ip_type after reset", ip_type, msg_unsupported);
		check_value("ip_done after reset", ip_done, 1'b0);
		check_value("udp_data_vld after reset", udp_data_vld, 1'b0);

		accepted_udp_packet(16'h1001, 12);
		rejected_packet(32'hC0A8_0002, PROTO_UDP, 16'h1002);
		rejected_packet(LOCAL_IP, 8'd1, 16'h1003);
		rejected_packet(LOCAL_IP, 8'd6, 16'h1004);
		wrong_udp_port(16'h1005);
		udp_watchdog_abort(16'h1006);
		accepted_udp_packet(16'h1007, 5);

		$display("Checks run: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- project.f
ip_decoder_pkg.sv
ip_header_capture.sv
udp_rx.sv
ip_rx_ctrl.sv
ip_decoder_top.sv
ip_decoder_props.sv
tb_clock_gen.sv
tb_ip_decoder.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ip_decoder
FILELIST = project.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
